/* source/cpu_stats_pkg.sv */
package cpu_stats_pkg;

    // widths and sizes
    localparam int count_w    = 27;   // holds 99,999,999
    localparam int num_digits = 8;    // seven-segment positions on the board
    localparam int scan_div   = 4;    // cycles per lit digit, raise for a board build

    typedef logic [count_w-1:0] count_t;
    typedef logic [31:0]        word_t;       // led data, or eight packed digits
    typedef logic [3:0]         digit_t;
    typedef logic [2:0]         digit_idx_t;
    typedef logic [7:0]         seg_t;        // active low, bit 7 is dp, 6..0 are g..a

    // display mode codes, 6 and 7 blank to zero
    typedef enum logic [2:0] {
        show_led      = 3'd0,
        show_cycle    = 3'd1,
        show_jump     = 3'd2,
        show_branch   = 3'd3,
        show_bubble   = 3'd4,
        show_load_use = 3'd5
    } display_sel_t;

    // hex digit to active-low segments, dp kept dark
    localparam seg_t seg_table [16] = '{
        8'hc0, // 0
        8'hf9, // 1
        8'ha4, // 2
        8'hb0, // 3
        8'h99, // 4
        8'h92, // 5
        8'h82, // 6
        8'hf8, // 7
        8'h80, // 8
        8'h90, // 9
        8'h88, // a
        8'h83, // b
        8'hc6, // c
        8'ha1, // d
        8'h86, // e
        8'h8e  // f
    };

endpackage

/* source/event_counters.sv */
module event_counters (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  jump_id,       // jal or jalr decoded
    input  logic                  branch_taken,  // taken conditional branch
    input  logic                  load_use,      // load-use bubble inserted
    input  logic                  halt,          // core parked on final ecall
    input  logic                  go,            // single step while halted
    output cpu_stats_pkg::count_t cycle_count,
    output cpu_stats_pkg::count_t jump_count,
    output cpu_stats_pkg::count_t branch_count,
    output cpu_stats_pkg::count_t load_use_count
);

    logic cycle_en;

    // core clock is live unless halted, go lets one cycle through
    assign cycle_en = !halt || go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else if (cycle_en) begin
            cycle_count <= cycle_count + 1'b1;  // wraps past the top
        end
    end

    // event strobes, one count per high cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_count     <= '0;
            branch_count   <= '0;
            load_use_count <= '0;
        end else begin
            if (jump_id) begin
                jump_count <= jump_count + 1'b1;
            end
            if (branch_taken) begin
                branch_count <= branch_count + 1'b1;
            end
            if (load_use) begin
                load_use_count <= load_use_count + 1'b1;
            end
        end
    end

endmodule

/* source/bin_to_bcd.sv */
module bin_to_bcd (
    input  cpu_stats_pkg::count_t bin,
    output cpu_stats_pkg::word_t  bcd
);

    localparam int bcd_w = cpu_stats_pkg::num_digits * 4;

    // shift-and-add-3, binary enters at the bottom and decimal grows above it
    always_comb begin
        logic [cpu_stats_pkg::count_w+bcd_w-1:0] work;
        cpu_stats_pkg::digit_t                   nib;

        work = '0;
        work[cpu_stats_pkg::count_w-1:0] = bin;

        for (int i = 0; i < cpu_stats_pkg::count_w; i++) begin
            // correct every digit that would pass 9 after the shift
            for (int d = 0; d < cpu_stats_pkg::num_digits; d++) begin
                nib = work[cpu_stats_pkg::count_w + 4*d +: 4];
                if (nib > 4'd4) begin
                    work[cpu_stats_pkg::count_w + 4*d +: 4] = nib + 4'd3;
                end
            end
            work = work << 1;
        end

        bcd = work[cpu_stats_pkg::count_w +: bcd_w];  // anything above 8 digits drops out
    end

endmodule

/* source/display_source.sv */
module display_source (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        led_write,
    input  cpu_stats_pkg::word_t        led_data,
    input  cpu_stats_pkg::display_sel_t display_sel,
    input  cpu_stats_pkg::count_t       cycle_count,
    input  cpu_stats_pkg::count_t       jump_count,
    input  cpu_stats_pkg::count_t       branch_count,
    input  cpu_stats_pkg::count_t       load_use_count,
    output cpu_stats_pkg::word_t        digits
);

    cpu_stats_pkg::word_t  led_value;  // last word from the ecall led service
    cpu_stats_pkg::count_t picked;
    cpu_stats_pkg::word_t  picked_bcd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_value <= '0;
        end else if (led_write) begin
            led_value <= led_data;
        end
    end

    // counter for the current mode
    always_comb begin
        case (display_sel)
            cpu_stats_pkg::show_cycle:    picked = cycle_count;
            cpu_stats_pkg::show_jump:     picked = jump_count;
            cpu_stats_pkg::show_branch:   picked = branch_count;
            cpu_stats_pkg::show_bubble:   picked = load_use_count;  // every bubble is a load-use
            cpu_stats_pkg::show_load_use: picked = load_use_count;
            default:                      picked = '0;  // led mode and codes 6, 7
        endcase
    end

    // one converter is enough, only one value is on the display
    bin_to_bcd u_bin_to_bcd (
        .bin (picked),
        .bcd (picked_bcd)
    );

    // led word goes out as raw hex nibbles
    assign digits = (display_sel == cpu_stats_pkg::show_led) ? led_value : picked_bcd;

endmodule

/* source/digit_scan.sv */
module digit_scan (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cpu_stats_pkg::word_t                digits,  // digit 0 in bits 3..0, rightmost
    output cpu_stats_pkg::seg_t                 seg,
    output logic [cpu_stats_pkg::num_digits-1:0] an
);

    // timer sized to hold scan_div - 1
    logic [$clog2(cpu_stats_pkg::scan_div+1)-1:0] scan_cnt;
    cpu_stats_pkg::digit_idx_t                    idx;
    cpu_stats_pkg::digit_t                        cur_digit;
    logic                                         step;

    assign step      = (int'(scan_cnt) == cpu_stats_pkg::scan_div - 1);
    assign cur_digit = digits[{idx, 2'b00} +: 4];

    // dwell timer and position counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            idx      <= '0;
        end else if (step) begin
            scan_cnt <= '0;
            if (int'(idx) == cpu_stats_pkg::num_digits - 1) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // anode and segments load in the same edge so they never disagree
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            an  <= '1;  // all dark
            seg <= '1;
        end else begin
            an  <= ~(8'b0000_0001 << idx);
            seg <= cpu_stats_pkg::seg_table[cur_digit];
        end
    end

endmodule

/* source/stats_display_top.sv */
module stats_display_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 jump_id,
    input  logic                                 branch_taken,
    input  logic                                 load_use,
    input  logic                                 halt,
    input  logic                                 go,
    input  logic                                 led_write,
    input  cpu_stats_pkg::word_t                 led_data,
    input  cpu_stats_pkg::display_sel_t          display_sel,
    output cpu_stats_pkg::seg_t                  seg,
    output logic [cpu_stats_pkg::num_digits-1:0] an
);

    cpu_stats_pkg::count_t cycle_count;
    cpu_stats_pkg::count_t jump_count;
    cpu_stats_pkg::count_t branch_count;
    cpu_stats_pkg::count_t load_use_count;
    cpu_stats_pkg::word_t  digits;  // eight nibbles on their way to the scanner

    event_counters u_event_counters (
        .clk            (clk),
        .rst_n          (rst_n),
        .jump_id        (jump_id),
        .branch_taken   (branch_taken),
        .load_use       (load_use),
        .halt           (halt),
        .go             (go),
        .cycle_count    (cycle_count),
        .jump_count     (jump_count),
        .branch_count   (branch_count),
        .load_use_count (load_use_count)
    );

    display_source u_display_source (
        .clk            (clk),
        .rst_n          (rst_n),
        .led_write      (led_write),
        .led_data       (led_data),
        .display_sel    (display_sel),
        .cycle_count    (cycle_count),
        .jump_count     (jump_count),
        .branch_count   (branch_count),
        .load_use_count (load_use_count),
        .digits         (digits)
    );

    // board-side seven-segment multiplexer
    digit_scan u_digit_scan (
        .clk    (clk),
        .rst_n  (rst_n),
        .digits (digits),
        .seg    (seg),
        .an     (an)
    );

endmodule

/* dv/stats_display_tb.sv */
module stats_display_tb;

    localparam int clk_half   = 20;
    localparam int scan_len   = cpu_stats_pkg::num_digits * cpu_stats_pkg::scan_div;
    localparam int settle_len = scan_len + 2;   // one full scan plus register delay
    localparam int random_len = 300;
    localparam int led_len    = 40;
    // reset, random events, led writes, then eight display windows
    localparam int planned_len = 2 + random_len + led_len + 8 * (settle_len + scan_len);
    localparam int cycle_limit = 2 * planned_len + 50;

    localparam cpu_stats_pkg::count_t count_step = 1;

    logic                        clk = 1'b0;  // low from the start, no edge at time zero
    logic                        rst_n;
    logic                        jump_id;
    logic                        branch_taken;
    logic                        load_use;
    logic                        halt;
    logic                        go;
    logic                        led_write;
    cpu_stats_pkg::word_t        led_data;
    cpu_stats_pkg::display_sel_t display_sel;
    cpu_stats_pkg::seg_t         seg;
    logic [7:0]                  an;

    logic [31:0]           lcg_state = 32'h75526c78;
    cpu_stats_pkg::count_t m_cycle;     // model counters
    cpu_stats_pkg::count_t m_jump;
    cpu_stats_pkg::count_t m_branch;
    cpu_stats_pkg::count_t m_load_use;
    cpu_stats_pkg::word_t  m_led;
    int                    scan_edges = 0;  // rising edges since reset release
    int                    cycle_cnt  = 0;

    stats_display_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .jump_id      (jump_id),
        .branch_taken (branch_taken),
        .load_use     (load_use),
        .halt         (halt),
        .go           (go),
        .led_write    (led_write),
        .led_data     (led_data),
        .display_sel  (display_sel),
        .seg          (seg),
        .an           (an)
    );

    initial begin
        forever #clk_half clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // eight decimal digits, least significant in bits 3..0
    function automatic cpu_stats_pkg::word_t decimal_word(cpu_stats_pkg::count_t val);
        cpu_stats_pkg::word_t w;
        int unsigned          v;
        w = '0;
        v = 32'(val);
        for (int d = 0; d < cpu_stats_pkg::num_digits; d++) begin
            w[4*d +: 4] = cpu_stats_pkg::digit_t'(v % 10);
            v = v / 10;
        end
        return w;
    endfunction

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_seg(input cpu_stats_pkg::seg_t got, input cpu_stats_pkg::seg_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: seg is %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_an(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: an is %b, expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic go_quiet();
        jump_id      = 1'b0;
        branch_taken = 1'b0;
        load_use     = 1'b0;
        halt         = 1'b1;  // freezes the cycle count while the display is read
        go           = 1'b0;
        led_write    = 1'b0;
    endtask

    // select a mode, let it settle, then read one full scan
    task automatic check_window(input cpu_stats_pkg::display_sel_t sel,
                                input cpu_stats_pkg::word_t exp_word);
        int lit;
        display_sel = sel;
        repeat (settle_len) @(negedge clk);
        repeat (scan_len) begin
            @(negedge clk);
            lit = -1;
            for (int p = 0; p < cpu_stats_pkg::num_digits; p++) begin
                if (an[p] == 1'b0) begin
                    lit = p;
                end
            end
            if (lit < 0) begin
                $display("no digit was lit at time %0t while reading the display", $time);
                stop_run();
            end
            check_seg(seg, cpu_stats_pkg::seg_table[exp_word[4*lit +: 4]]);
        end
    endtask

    // reference model, same rules as the core statistics
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_cycle    <= '0;
            m_jump     <= '0;
            m_branch   <= '0;
            m_load_use <= '0;
            m_led      <= '0;
            scan_edges <= 0;
        end else begin
            if (!halt || go) begin
                m_cycle <= m_cycle + count_step;
            end
            if (jump_id) begin
                m_jump <= m_jump + count_step;
            end
            if (branch_taken) begin
                m_branch <= m_branch + count_step;
            end
            if (load_use) begin
                m_load_use <= m_load_use + count_step;
            end
            if (led_write) begin
                m_led <= led_data;
            end
            scan_edges <= scan_edges + 1;
        end
    end

    // anode check every cycle, dark until the first load after reset
    always @(negedge clk) begin
        int exp_pos;
        if (scan_edges == 0) begin
            check_an(an, 8'hff);
            check_seg(seg, 8'hff);
        end else begin
            exp_pos = ((scan_edges - 1) / cpu_stats_pkg::scan_div) % cpu_stats_pkg::num_digits;
            check_an(an, ~(8'h01 << exp_pos));
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the display checks did not finish", cycle_cnt);
            stop_run();
        end
    end

    initial begin
        logic [31:0] r;
        rst_n        = 1'b0;
        jump_id      = 1'b0;
        branch_taken = 1'b0;
        load_use     = 1'b0;
        halt         = 1'b0;
        go           = 1'b0;
        led_write    = 1'b0;
        led_data     = '0;
        display_sel  = cpu_stats_pkg::show_led;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // random core events, halted about a third of the time
        repeat (random_len) begin
            @(negedge clk);
            r            = next_rand();
            jump_id      = r[4];
            branch_taken = r[9];
            load_use     = r[13];
            halt         = ((r[23:16] % 8'd3) == 8'd0);
            go           = (r[27:25] == 3'd0);
            display_sel  = cpu_stats_pkg::display_sel_t'(r[30:28]);
        end
        @(negedge clk);
        go_quiet();

        check_window(cpu_stats_pkg::show_cycle, decimal_word(m_cycle));
        check_window(cpu_stats_pkg::show_jump, decimal_word(m_jump));
        check_window(cpu_stats_pkg::show_branch, decimal_word(m_branch));
        check_window(cpu_stats_pkg::show_bubble, decimal_word(m_load_use));
        check_window(cpu_stats_pkg::show_load_use, decimal_word(m_load_use));

        // led service writes, first one always taken
        for (int i = 0; i < led_len; i++) begin
            @(negedge clk);
            r         = next_rand();
            led_write = (i == 0) || (r[1:0] == 2'b00);
            led_data  = next_rand();
        end
        @(negedge clk);
        go_quiet();
        check_window(cpu_stats_pkg::show_led, m_led);

        // codes 6 and 7 blank to zero
        check_window(cpu_stats_pkg::display_sel_t'(3'd6), '0);
        check_window(cpu_stats_pkg::display_sel_t'(3'd7), '0);

        $display("Everything OK");
        $finish;
    end

endmodule

/* src.f */
source/cpu_stats_pkg.sv
source/event_counters.sv
source/bin_to_bcd.sv
source/display_source.sv
source/digit_scan.sv
source/stats_display_top.sv
dv/stats_display_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the statistics display testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f \
    --top-module stats_display_tb --Mdir obj_dir -o stats_display_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/stats_display_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi
exit "$sim_status"
